//--- Bender.yml
package:
  name: dcache_core

sources:
  - files:
      - verilog/dcache_pkg.sv
      - verilog/lsu_pkg.sv
      - verilog/dcache_dt.sv
      - verilog/dcache_tag_array.sv
      - verilog/dcache_data_array.sv
      - verilog/dcache_load_align.sv
      - verilog/dcache_core.sv
  - target: test
    files:
      - tests/dcache_core_checker.sv
      - tests/dcache_core_tb.sv

//--- sources.f
verilog/dcache_pkg.sv
verilog/lsu_pkg.sv
verilog/dcache_dt.sv
verilog/dcache_tag_array.sv
verilog/dcache_data_array.sv
verilog/dcache_load_align.sv
verilog/dcache_core.sv
tests/dcache_core_checker.sv
tests/dcache_core_tb.sv

//--- tests/dcache_core_checker.sv
/*
 * Data cache protocol checker.
 * Bound to the cache top level. Watches completion timing against the
 * request strobe and the behavior of o_done around reset.
 */

`default_nettype none

module dcache_core_checker (
    input logic clk,
    input logic i_rst_n,
    input logic i_req,
    input logic i_fill,
    input logic i_done,
    input logic i_hit
);

    int fail_count = 0;  // Read by the testbench at the end of the run.

    // =========================================================================
    // Completion timing
    // =========================================================================

    done_after_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        (i_req && !i_fill) |-> ##2 i_done)
        else begin
            $error("o_done missing two cycles after an accepted request");
            fail_count++;
        end

    done_has_req: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_done |-> $past(i_req && !i_fill, 2))
        else begin
            $error("o_done without an accepted request two cycles earlier");
            fail_count++;
        end

    hit_needs_done: assert property (@(posedge clk) disable iff (!i_rst_n)
        i_hit |-> i_done)
        else begin
            $error("o_hit high without o_done");
            fail_count++;
        end

    // The response pipe is empty during reset and one cycle beyond it.
    done_low_in_reset: assert property (@(posedge clk)
        !i_rst_n |=> !i_done ##1 !i_done)
        else begin
            $error("o_done high during or right after reset");
            fail_count++;
        end

endmodule

bind dcache_core dcache_core_checker dcache_core_checker_inst (
    .clk    (clk),
    .i_rst_n(i_rst_n),
    .i_req  (i_req),
    .i_fill (i_fill),
    .i_done (o_done),
    .i_hit  (o_hit)
);

`default_nettype wire

//--- tests/dcache_core_tb.sv
/*
 * Data cache testbench.
 * Directed tests against a reference model of lines, tags and valid
 * bits. Responses are checked in issue order as o_done pulses arrive.
 */

`default_nettype none

module dcache_core_tb;

    logic                  clk = 1'b0;
    logic                  i_rst_n;
    logic                  i_req;
    logic                  i_wr_en;
    dcache_pkg::addr_t     i_addr;
    lsu_pkg::lsu_func_t    i_lsu_func;
    dcache_pkg::word_t     i_wdata;
    logic                  i_fill;
    dcache_pkg::addr_t     i_fill_addr;
    logic [127:0]          i_fill_data;
    logic                  o_done;
    logic                  o_hit;
    dcache_pkg::word_t     o_rdata;

    // Reference model for 16 lines of 16 bytes.
    logic [127:0] ref_line [16];
    logic [23:0]  ref_tag [16];
    logic         ref_valid [16];
    logic [32:0]  exp_q [$];  // {hit, rdata} per request in issue order.
    logic [32:0]  exp_entry;
    int           err_count = 0;
    int           check_count = 0;
    int           last_errs = 0;

    dcache_core dcache_core_inst (.*);

    always #50 clk = ~clk;

    task automatic check_val(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            $display("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp);
            err_count++;
        end
    endtask

    // Outputs are registered, so they are steady at the falling edge.
    always @(negedge clk) begin
        if (i_rst_n === 1'b1 && o_done === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Unexpected o_done at time %0t with no request outstanding", $time);
                err_count++;
            end else begin
                exp_entry = exp_q.pop_front();
                check_val("o_hit", 32'(o_hit), 32'(exp_entry[32]));
                check_val("o_rdata", o_rdata, exp_entry[31:0]);
            end
        end
    end

    task automatic send_access(input logic wr, input dcache_pkg::addr_t a,
                               input lsu_pkg::lsu_func_t f, input dcache_pkg::word_t wd);
        logic [3:0]        idx;
        logic              hit;
        logic [7:0]        b;
        logic [15:0]       h;
        dcache_pkg::word_t rd;
        int                nbytes;
        @(negedge clk);
        i_req      = 1'b1;
        i_fill     = 1'b0;
        i_wr_en    = wr;
        i_addr     = a;
        i_lsu_func = f;
        i_wdata    = wd;
        idx = a[7:4];
        hit = ref_valid[idx] && (ref_tag[idx] == a[31:8]);
        b   = ref_line[idx][a[3:0]*8 +: 8];
        h   = ref_line[idx][a[3:1]*16 +: 16];
        rd  = '0;
        nbytes = (f == lsu_pkg::LSU_SB) ? 1 : (f == lsu_pkg::LSU_SH) ? 2 : 4;
        if (hit && wr) begin
            for (int i = 0; i < nbytes; i++) begin
                ref_line[idx][(a[3:0]+i)*8 +: 8] = wd[i*8 +: 8];
            end
        end else if (hit) begin
            case (f)
                lsu_pkg::LSU_LB:  rd = {{24{b[7]}}, b};
                lsu_pkg::LSU_LBU: rd = {24'h0, b};
                lsu_pkg::LSU_LH:  rd = {{16{h[15]}}, h};
                lsu_pkg::LSU_LHU: rd = {16'h0, h};
                default:          rd = ref_line[idx][a[3:2]*32 +: 32];
            endcase
        end
        exp_q.push_back({hit, rd});
    endtask

    // With with_req set, a load rides along with the fill and must be dropped.
    task automatic fill_line(input dcache_pkg::addr_t a, input logic [127:0] d,
                             input logic with_req);
        @(negedge clk);
        i_fill      = 1'b1;
        i_fill_addr = a;
        i_fill_data = d;
        i_req       = with_req;
        i_wr_en     = 1'b0;
        i_addr      = a;
        i_lsu_func  = lsu_pkg::LSU_LW;
        ref_line[a[7:4]]  = d;
        ref_tag[a[7:4]]   = a[31:8];
        ref_valid[a[7:4]] = 1'b1;
    endtask

    task automatic go_idle();
        @(negedge clk);
        i_req   = 1'b0;
        i_fill  = 1'b0;
        i_wr_en = 1'b0;
    endtask

    task automatic wait_drain();
        int cycles;
        go_idle();
        cycles = 0;
        while (exp_q.size() != 0 && cycles < 10) begin
            @(negedge clk);
            cycles++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d requests got no o_done within 10 cycles", exp_q.size());
            err_count++;
            exp_q.delete();
        end
    endtask

    task automatic end_test(input string name);
        $display("Test %s finished with %0d errors", name, err_count - last_errs);
        last_errs = err_count;
    endtask

    // =========================================================================
    // Tests
    // =========================================================================

    task automatic miss_after_reset();
        send_access(1'b0, 32'h0000_0000, lsu_pkg::LSU_LW, '0);
        send_access(1'b0, 32'h0000_0104, lsu_pkg::LSU_LW, '0);
        send_access(1'b0, 32'h0000_abc0, lsu_pkg::LSU_LW, '0);
        send_access(1'b0, 32'hffff_fffc, lsu_pkg::LSU_LW, '0);
        wait_drain();
        end_test("miss_after_reset");
    endtask

    task automatic load_filled_line();
        fill_line(32'h0000_1230, {$urandom, $urandom, $urandom, $urandom}, 1'b0);
        for (int w = 0; w < 4; w++) begin
            send_access(1'b0, 32'h0000_1230 + w*4, lsu_pkg::LSU_LW, '0);
        end
        send_access(1'b0, 32'h0000_5634, lsu_pkg::LSU_LW, '0);  // Same index, other tag.
        wait_drain();
        end_test("load_filled_line");
    endtask

    task automatic sub_word_loads();
        fill_line(32'h0000_2040, 128'h80ff7f01_f0e1d2c3_8a9bacbd_7e80fe01, 1'b0);
        for (int a = 0; a < 16; a++) begin
            send_access(1'b0, 32'h0000_2040 + a, lsu_pkg::LSU_LB, '0);
            send_access(1'b0, 32'h0000_2040 + a, lsu_pkg::LSU_LBU, '0);
            if (a % 2 == 0) begin
                send_access(1'b0, 32'h0000_2040 + a, lsu_pkg::LSU_LH, '0);
                send_access(1'b0, 32'h0000_2040 + a, lsu_pkg::LSU_LHU, '0);
            end
        end
        wait_drain();
        end_test("sub_word_loads");
    endtask

    task automatic store_merge();
        fill_line(32'h0000_3000, {$urandom, $urandom, $urandom, $urandom}, 1'b0);
        send_access(1'b1, 32'h0000_3001, lsu_pkg::LSU_SB, 32'h0000_00a5);
        send_access(1'b1, 32'h0000_3006, lsu_pkg::LSU_SH, 32'h0000_beef);
        send_access(1'b1, 32'h0000_3008, lsu_pkg::LSU_SW, 32'h1234_5678);
        send_access(1'b1, 32'h0000_300f, lsu_pkg::LSU_SB, 32'h0000_003c);
        for (int w = 0; w < 4; w++) begin
            send_access(1'b0, 32'h0000_3000 + w*4, lsu_pkg::LSU_LW, '0);
        end
        // Line 0 holds the 0x3000 tag, so this store misses.
        send_access(1'b1, 32'h0000_7004, lsu_pkg::LSU_SW, 32'hdead_beef);
        send_access(1'b0, 32'h0000_3004, lsu_pkg::LSU_LW, '0);  // Resident line is untouched.
        fill_line(32'h0000_7000, {$urandom, $urandom, $urandom, $urandom}, 1'b0);
        send_access(1'b0, 32'h0000_7004, lsu_pkg::LSU_LW, '0);
        wait_drain();
        end_test("store_merge");
    endtask

    task automatic fill_collision();
        fill_line(32'h0000_4050, {$urandom, $urandom, $urandom, $urandom}, 1'b1);
        send_access(1'b0, 32'h0000_4058, lsu_pkg::LSU_LW, '0);
        wait_drain();
        end_test("fill_collision");
    endtask

    task automatic random_mix();
        lsu_pkg::lsu_func_t funcs [8];
        lsu_pkg::lsu_func_t f;
        dcache_pkg::addr_t  a;
        int                 kind;
        funcs = '{lsu_pkg::LSU_LB, lsu_pkg::LSU_LH, lsu_pkg::LSU_LW, lsu_pkg::LSU_LBU,
                  lsu_pkg::LSU_LHU, lsu_pkg::LSU_SB, lsu_pkg::LSU_SH, lsu_pkg::LSU_SW};
        for (int n = 0; n < 200; n++) begin
            kind = $urandom % 8;
            a    = $urandom % 512;  // Two tags compete for each line.
            if (kind == 0) begin
                fill_line(a & ~32'hf, {$urandom, $urandom, $urandom, $urandom}, 1'b0);
            end else begin
                f = funcs[$urandom % 8];
                if (f inside {lsu_pkg::LSU_LW, lsu_pkg::LSU_SW}) begin
                    a[1:0] = 2'b00;
                end else if (f inside {lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH}) begin
                    a[0] = 1'b0;
                end
                send_access(f inside {lsu_pkg::LSU_SB, lsu_pkg::LSU_SH, lsu_pkg::LSU_SW},
                            a, f, $urandom);
            end
        end
        wait_drain();
        end_test("random_mix");
    endtask

    initial begin
        void'($urandom(40));
        i_rst_n     = 1'b0;
        i_req       = 1'b0;
        i_wr_en     = 1'b0;
        i_addr      = '0;
        i_lsu_func  = lsu_pkg::LSU_LW;
        i_wdata     = '0;
        i_fill      = 1'b0;
        i_fill_addr = '0;
        i_fill_data = '0;
        for (int i = 0; i < 16; i++) begin
            ref_valid[i] = 1'b0;
        end
        repeat (10) @(posedge clk);
        @(negedge clk);
        i_rst_n = 1'b1;

        miss_after_reset();
        load_filled_line();
        sub_word_loads();
        store_merge();
        fill_collision();
        random_mix();

        err_count += dcache_core_inst.dcache_core_checker_inst.fail_count;
        $display("Summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_core.sv
/*
 * Direct-mapped data cache pipeline.
 * Request stage, tag and data arrays working side by side, and the
 * load alignment that produces the response two cycles after a request.
 */

`default_nettype none

module dcache_core #(
    parameter  int P_CACHE_SIZE = 256,
    parameter  int P_LINE_SIZE  = 16,
    localparam int LINE_WIDTH   = P_LINE_SIZE * 8,
    localparam int OFFSET_WIDTH = $clog2(P_LINE_SIZE),
    localparam int INDEX_WIDTH  = $clog2(P_CACHE_SIZE / P_LINE_SIZE),
    localparam int TAG_WIDTH    = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_req,
    input  logic                  i_wr_en,
    input  dcache_pkg::addr_t     i_addr,
    input  lsu_pkg::lsu_func_t    i_lsu_func,
    input  dcache_pkg::word_t     i_wdata,
    input  logic                  i_fill,
    input  dcache_pkg::addr_t     i_fill_addr,
    input  logic [LINE_WIDTH-1:0] i_fill_data,

    output logic                  o_done,
    output logic                  o_hit,
    output dcache_pkg::word_t     o_rdata
);

    // Stage 1.
    logic                    s1_req;
    logic                    s1_wr_en;
    logic                    s1_fill;
    logic [TAG_WIDTH-1:0]    s1_tag;
    logic [INDEX_WIDTH-1:0]  s1_index;
    logic [OFFSET_WIDTH-1:0] s1_offset;
    lsu_pkg::lsu_func_t      s1_lsu_func;
    dcache_pkg::byte_sel_t   s1_byte_sel;
    dcache_pkg::word_t       s1_wdata;
    logic [LINE_WIDTH-1:0]   s1_fill_data;
    logic                    s1_lookup_hit;

    // Stage 2.
    logic                    s2_hit;
    dcache_pkg::word_t       s2_word;

    dcache_dt #(
        .P_CACHE_SIZE(P_CACHE_SIZE),
        .P_LINE_SIZE (P_LINE_SIZE)
    ) dcache_dt_inst (
        .clk        (clk),
        .i_rst_n    (i_rst_n),
        .i_req      (i_req),
        .i_wr_en    (i_wr_en),
        .i_addr     (i_addr),
        .i_lsu_func (i_lsu_func),
        .i_wdata    (i_wdata),
        .i_fill     (i_fill),
        .i_fill_addr(i_fill_addr),
        .i_fill_data(i_fill_data),
        .o_req      (s1_req),
        .o_wr_en    (s1_wr_en),
        .o_fill     (s1_fill),
        .o_tag      (s1_tag),
        .o_index    (s1_index),
        .o_offset   (s1_offset),
        .o_lsu_func (s1_lsu_func),
        .o_byte_sel (s1_byte_sel),
        .o_wdata    (s1_wdata),
        .o_fill_data(s1_fill_data)
    );

    dcache_tag_array #(
        .P_CACHE_SIZE(P_CACHE_SIZE),
        .P_LINE_SIZE (P_LINE_SIZE)
    ) dcache_tag_array_inst (
        .clk         (clk),
        .i_rst_n     (i_rst_n),
        .i_req       (s1_req),
        .i_wr_en     (s1_wr_en),
        .i_fill      (s1_fill),
        .i_tag       (s1_tag),
        .i_index     (s1_index),
        .o_lookup_hit(s1_lookup_hit),
        .o_hit       (s2_hit),
        .o_dirty     ()
    );

    dcache_data_array #(
        .P_CACHE_SIZE(P_CACHE_SIZE),
        .P_LINE_SIZE (P_LINE_SIZE)
    ) dcache_data_array_inst (
        .clk         (clk),
        .i_req       (s1_req),
        .i_wr_en     (s1_wr_en),
        .i_fill      (s1_fill),
        .i_lookup_hit(s1_lookup_hit),
        .i_index     (s1_index),
        .i_offset    (s1_offset),
        .i_byte_sel  (s1_byte_sel),
        .i_wdata     (s1_wdata),
        .i_fill_data (s1_fill_data),
        .o_word      (s2_word)
    );

    dcache_load_align dcache_load_align_inst (
        .clk          (clk),
        .i_rst_n      (i_rst_n),
        .i_req        (s1_req),
        .i_wr_en      (s1_wr_en),
        .i_lsu_func   (s1_lsu_func),
        .i_byte_offset(s1_offset[1:0]),
        .i_hit        (s2_hit),
        .i_word       (s2_word),
        .o_done       (o_done),
        .o_hit        (o_hit),
        .o_rdata      (o_rdata)
    );

endmodule

`default_nettype wire

//--- verilog/dcache_data_array.sv
/*
 * Data cache line storage.
 * Writes whole lines on a fill, merges store bytes into the addressed
 * word on a store hit, and registers the addressed word into stage 2.
 */

`default_nettype none

module dcache_data_array #(
    parameter  int P_CACHE_SIZE = 256,
    parameter  int P_LINE_SIZE  = 16,
    localparam int LINE_WIDTH   = P_LINE_SIZE * 8,
    localparam int OFFSET_WIDTH = $clog2(P_LINE_SIZE),
    localparam int INDEX_WIDTH  = $clog2(P_CACHE_SIZE / P_LINE_SIZE)
) (
    input  logic                    clk,
    input  logic                    i_req,
    input  logic                    i_wr_en,
    input  logic                    i_fill,
    input  logic                    i_lookup_hit,
    input  logic [INDEX_WIDTH-1:0]  i_index,
    input  logic [OFFSET_WIDTH-1:0] i_offset,
    input  dcache_pkg::byte_sel_t   i_byte_sel,
    input  dcache_pkg::word_t       i_wdata,
    input  logic [LINE_WIDTH-1:0]   i_fill_data,

    output dcache_pkg::word_t       o_word
);

    localparam int NUM_LINES  = P_CACHE_SIZE / P_LINE_SIZE;
    localparam int LANE_WIDTH = $clog2(dcache_pkg::DATA_SIZE);

    logic [LINE_WIDTH-1:0]   line_mem [NUM_LINES];
    logic [LINE_WIDTH-1:0]   cur_line;
    logic [LINE_WIDTH-1:0]   new_line;
    logic [OFFSET_WIDTH-1:0] word_idx;
    logic [LANE_WIDTH-1:0]   lane;
    dcache_pkg::byte_sel_t   byte_en;
    dcache_pkg::word_t       wdata_sh;
    dcache_pkg::word_t       cur_word;
    dcache_pkg::word_t       merged_word;
    logic                    store_hit;

    assign cur_line  = line_mem[i_index];
    assign word_idx  = i_offset >> LANE_WIDTH;  // Word within the line.
    assign lane      = i_offset[LANE_WIDTH-1:0];
    assign cur_word  = cur_line[word_idx*dcache_pkg::DATA_WIDTH +: dcache_pkg::DATA_WIDTH];
    assign store_hit = i_req & i_wr_en & i_lookup_hit;

    // Move the lane-0 mask and data up to the byte offset of the access.
    assign byte_en  = i_byte_sel << lane;
    assign wdata_sh = i_wdata << {lane, 3'b000};

    always_comb begin
        for (int b = 0; b < dcache_pkg::DATA_SIZE; b++) begin
            merged_word[b*8 +: 8] = byte_en[b] ? wdata_sh[b*8 +: 8] : cur_word[b*8 +: 8];
        end
        new_line = cur_line;
        new_line[word_idx*dcache_pkg::DATA_WIDTH +: dcache_pkg::DATA_WIDTH] = merged_word;
    end

    // =========================================================================
    // Storage
    // =========================================================================

    always_ff @(posedge clk) begin
        if (i_fill) begin
            line_mem[i_index] <= i_fill_data;
        end else if (store_hit) begin
            line_mem[i_index] <= new_line;  // A store miss writes nothing.
        end
    end

    always_ff @(posedge clk) begin
        o_word <= cur_word;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_dt.sv
/*
 * Data cache request stage.
 * Registers a load, store or line fill into stage 1, splits the address
 * into tag, index and offset, and derives the byte-lane mask.
 */

`default_nettype none

module dcache_dt #(
    parameter  int P_CACHE_SIZE = 256,
    parameter  int P_LINE_SIZE  = 16,
    localparam int LINE_WIDTH   = P_LINE_SIZE * 8,
    localparam int OFFSET_WIDTH = $clog2(P_LINE_SIZE),
    localparam int INDEX_WIDTH  = $clog2(P_CACHE_SIZE / P_LINE_SIZE),
    localparam int TAG_WIDTH    = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                  clk,
    input  logic                  i_rst_n,
    input  logic                  i_req,
    input  logic                  i_wr_en,
    input  dcache_pkg::addr_t     i_addr,
    input  lsu_pkg::lsu_func_t    i_lsu_func,
    input  dcache_pkg::word_t     i_wdata,
    input  logic                  i_fill,
    input  dcache_pkg::addr_t     i_fill_addr,
    input  logic [LINE_WIDTH-1:0] i_fill_data,

    output logic                    o_req,
    output logic                    o_wr_en,
    output logic                    o_fill,
    output logic [TAG_WIDTH-1:0]    o_tag,
    output logic [INDEX_WIDTH-1:0]  o_index,
    output logic [OFFSET_WIDTH-1:0] o_offset,
    output lsu_pkg::lsu_func_t      o_lsu_func,
    output dcache_pkg::byte_sel_t   o_byte_sel,
    output dcache_pkg::word_t       o_wdata,
    output logic [LINE_WIDTH-1:0]   o_fill_data
);

    dcache_pkg::addr_t     addr;
    dcache_pkg::byte_sel_t byte_sel;

    assign addr = i_fill ? i_fill_addr : i_addr;  // A fill takes the slot.

    // Lanes start at lane 0 and are moved to the offset in the data array.
    always_comb begin
        case (i_lsu_func)
            lsu_pkg::LSU_LB, lsu_pkg::LSU_LBU, lsu_pkg::LSU_SB:
                byte_sel = dcache_pkg::byte_sel_t'(1'b1);
            lsu_pkg::LSU_LH, lsu_pkg::LSU_LHU, lsu_pkg::LSU_SH:
                byte_sel = dcache_pkg::byte_sel_t'(2'b11);
            default:
                byte_sel = '1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_req   <= 1'b0;
            o_wr_en <= 1'b0;
            o_fill  <= 1'b0;
        end else begin
            o_req   <= i_req & ~i_fill;  // Request is dropped under a fill.
            o_wr_en <= i_wr_en & ~i_fill;
            o_fill  <= i_fill;
        end
    end

    always_ff @(posedge clk) begin
        o_tag       <= addr[dcache_pkg::ADDR_WIDTH-1 -: TAG_WIDTH];
        o_index     <= addr[OFFSET_WIDTH +: INDEX_WIDTH];
        o_offset    <= i_addr[OFFSET_WIDTH-1:0];
        o_lsu_func  <= i_lsu_func;
        o_byte_sel  <= byte_sel;
        o_wdata     <= i_wdata;
        o_fill_data <= i_fill_data;
    end

endmodule

`default_nettype wire

//--- verilog/dcache_load_align.sv
/*
 * Data cache load alignment.
 * Carries the request into stage 2, picks the byte or halfword out of
 * the read word, extends it and reports completion and hit.
 */

`default_nettype none

module dcache_load_align (
    input  logic               clk,
    input  logic               i_rst_n,
    input  logic               i_req,
    input  logic               i_wr_en,
    input  lsu_pkg::lsu_func_t i_lsu_func,
    input  logic [1:0]         i_byte_offset,
    input  logic               i_hit,
    input  dcache_pkg::word_t  i_word,

    output logic               o_done,
    output logic               o_hit,
    output dcache_pkg::word_t  o_rdata
);

    logic               req_q;
    logic               wr_en_q;
    lsu_pkg::lsu_func_t lsu_func_q;
    logic [1:0]         byte_offset_q;
    dcache_pkg::word_t  byte_shift;
    dcache_pkg::word_t  half_shift;
    dcache_pkg::word_t  load_data;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            req_q   <= 1'b0;
            wr_en_q <= 1'b0;
        end else begin
            req_q   <= i_req;
            wr_en_q <= i_wr_en;
        end
    end

    always_ff @(posedge clk) begin
        lsu_func_q    <= i_lsu_func;
        byte_offset_q <= i_byte_offset;
    end

    assign byte_shift = i_word >> {byte_offset_q, 3'b000};
    assign half_shift = i_word >> {byte_offset_q[1], 4'b0000};  // Halfwords are aligned.

    always_comb begin
        case (lsu_func_q)
            lsu_pkg::LSU_LB:  load_data = {{(dcache_pkg::DATA_WIDTH-8){byte_shift[7]}},
                                           byte_shift[7:0]};
            lsu_pkg::LSU_LBU: load_data = {{(dcache_pkg::DATA_WIDTH-8){1'b0}}, byte_shift[7:0]};
            lsu_pkg::LSU_LH:  load_data = {{(dcache_pkg::DATA_WIDTH-16){half_shift[15]}},
                                           half_shift[15:0]};
            lsu_pkg::LSU_LHU: load_data = {{(dcache_pkg::DATA_WIDTH-16){1'b0}}, half_shift[15:0]};
            default:          load_data = i_word;
        endcase
    end

    assign o_done  = req_q;
    assign o_hit   = i_hit;  // The tag array already qualifies its hit with the request.
    // Stores and misses return zero.
    assign o_rdata = (o_hit && !wr_en_q) ? load_data : '0;

endmodule

`default_nettype wire

//--- verilog/dcache_pkg.sv
/*
 * Data cache common definitions.
 * Holds the address and word widths shared by the cache blocks and the
 * vector types for addresses, data words and byte-lane masks.
 */

`default_nettype none

package dcache_pkg;

    // =========================================================================
    // Widths
    // =========================================================================

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int DATA_SIZE  = DATA_WIDTH / 8;  // Bytes per word.

    // =========================================================================
    // Types
    // =========================================================================

    // Byte address as seen by the load/store unit.
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // One data word.
    typedef logic [DATA_WIDTH-1:0] word_t;

    // One bit per byte lane of a word.
    typedef logic [DATA_SIZE-1:0]  byte_sel_t;

endpackage

`default_nettype wire

//--- verilog/dcache_tag_array.sv
/*
 * Data cache tag array.
 * Keeps a tag, valid bit and dirty bit per line, looks up hits for the
 * stage-1 request, installs tags on a fill and marks lines on store hits.
 */

`default_nettype none

module dcache_tag_array #(
    parameter  int P_CACHE_SIZE = 256,
    parameter  int P_LINE_SIZE  = 16,
    localparam int OFFSET_WIDTH = $clog2(P_LINE_SIZE),
    localparam int INDEX_WIDTH  = $clog2(P_CACHE_SIZE / P_LINE_SIZE),
    localparam int TAG_WIDTH    = dcache_pkg::ADDR_WIDTH - INDEX_WIDTH - OFFSET_WIDTH
) (
    input  logic                   clk,
    input  logic                   i_rst_n,
    input  logic                   i_req,
    input  logic                   i_wr_en,
    input  logic                   i_fill,
    input  logic [TAG_WIDTH-1:0]   i_tag,
    input  logic [INDEX_WIDTH-1:0] i_index,

    output logic                   o_lookup_hit,
    output logic                   o_hit,
    output logic                   o_dirty
);

    localparam int NUM_LINES = P_CACHE_SIZE / P_LINE_SIZE;

    logic [TAG_WIDTH-1:0] tag_mem [NUM_LINES];
    logic [NUM_LINES-1:0] valid_mem;
    logic [NUM_LINES-1:0] dirty_mem;
    logic                 store_hit;

    // =========================================================================
    // Lookup
    // =========================================================================

    assign o_lookup_hit = valid_mem[i_index] && (tag_mem[i_index] == i_tag);
    assign store_hit    = i_req & i_wr_en & o_lookup_hit;

    // =========================================================================
    // Update
    // =========================================================================

    always_ff @(posedge clk) begin
        if (i_fill) begin
            tag_mem[i_index] <= i_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            valid_mem <= '0;  // Every access misses until the first fill.
            dirty_mem <= '0;
        end else if (i_fill) begin
            valid_mem[i_index] <= 1'b1;
            dirty_mem[i_index] <= 1'b0;
        end else if (store_hit) begin
            dirty_mem[i_index] <= 1'b1;
        end
    end

    // Stage 2 results. o_dirty waits for a write-back stage.
    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            o_hit   <= 1'b0;
            o_dirty <= 1'b0;
        end else begin
            o_hit   <= i_req & o_lookup_hit;
            o_dirty <= dirty_mem[i_index];
        end
    end

endmodule

`default_nettype wire

//--- verilog/lsu_pkg.sv
/*
 * Load/store unit function codes.
 * Encodes the access kind and size of every LSU operation.
 */

`default_nettype none

package lsu_pkg;

    localparam int LSU_FUNC_WIDTH = 4;

    typedef logic [LSU_FUNC_WIDTH-1:0] lsu_func_t;

    // Loads. The U variants zero-extend.
    localparam lsu_func_t LSU_LB  = 4'b0000;
    localparam lsu_func_t LSU_LH  = 4'b0001;
    localparam lsu_func_t LSU_LW  = 4'b0010;
    localparam lsu_func_t LSU_LBU = 4'b0011;
    localparam lsu_func_t LSU_LHU = 4'b0100;

    // Stores.
    localparam lsu_func_t LSU_SB  = 4'b0101;
    localparam lsu_func_t LSU_SH  = 4'b0110;
    localparam lsu_func_t LSU_SW  = 4'b0111;

endpackage

`default_nettype wire
